// File: Makefile
TOOL     = verilator
TOP      = rpDriveTb
FILELIST = tb.f
FLAGS    = --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
PASS     = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/rpDriveTb.sv
// Self-checking testbench for the drive, run as top module rpDriveTb with the tb.f file list
module rpDriveTb;
   import rpRegPkg::*;
   import rpSeekPkg::*;

   // Longest timed move plus some slack for the writes around it
   localparam int maxMoveCycles = 1023 * seekCyclesPerCyl + seekSettle + 32;
   // At most seven timed moves in the sequence, one spare
   localparam int timeoutCycles = 8 * maxMoveCycles;
   localparam logic [31:0] lfsrTaps = 32'h8020_0003;

   logic     clk;
   logic     rst;
   logic     wrStb;
   rpBusWr_t wr;
   rpAddr_t  rdAddr;
   rpWord_t  rdData;
   logic     ata;

   // Reference model state
   rpCyl_t   mCc;
   rpCyl_t   mDc;
   rpFunc_t  mFunc;
   logic     mDmd;
   logic     mAta;
   logic     mPip;
   logic     mPipLast;
   logic     mSeeking;
   int       mCount;
   // Accepted commands, one and two edges after the write
   rpCmd_t   pendA;
   rpCmd_t   pendB;
   rpCmd_t   goCmd;
   logic     modelBusy;
   logic     pipEdge;
   rpWord_t  expWord;

   int          readErrors;
   int          ataErrors;
   int          cycleCount;
   logic [31:0] lfsrState;

   rpDrive DUT (
      .clk    (clk),
      .rst    (rst),
      .wrStb  (wrStb),
      .wr     (wr),
      .rdAddr (rdAddr),
      .rdData (rdData),
      .ata    (ata)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic int cylDistance(rpCyl_t a, rpCyl_t b);
      if (a > b)
         return int'(a - b);
      else
         return int'(b - a);
   endfunction

   // Drive counts as busy once a move is accepted
   assign modelBusy = mPip | pendA.seek | pendA.recal | pendB.seek | pendB.recal;

   // Pip about to change or just changed
   assign pipEdge = pendB.seek | pendB.recal | (mPip != mPipLast) | (mPip & (mCount == 1));

   // GO writes to CS1, positioning dropped while busy
   always_comb
   begin
      goCmd = '0;
      if (wrStb && wr.addr == addrCs1 && wr.data[0])
      begin
         case (rpFunc_t'(wr.data[5:1]))
            funcSeek   : goCmd.seek   = ~modelBusy;
            funcRecal  : goCmd.recal  = ~modelBusy;
            funcDclr   : goCmd.dclr   = 1'b1;
            funcPreset : goCmd.preset = 1'b1;
            default    : goCmd = '0;
         endcase
      end
   end

   // Later assignments win, so clears come before sets
   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mCc      <= '0;
         mDc      <= '0;
         mFunc    <= '0;
         mDmd     <= 1'b0;
         mAta     <= 1'b0;
         mPip     <= 1'b0;
         mPipLast <= 1'b0;
         mSeeking <= 1'b0;
         mCount   <= 0;
         pendA    <= '0;
         pendB    <= '0;
      end
      else
      begin
         pendA    <= goCmd;
         pendB    <= pendA;
         mPipLast <= mPip;
         if (pendB.dclr)
            mAta <= 1'b0;
         // Move finishes, heads land on the old target
         if (mPip)
         begin
            if (mCount == 1)
            begin
               mPip <= 1'b0;
               mAta <= 1'b1;
               if (mSeeking)
                  mCc <= mDc;
            end
            else
               mCount <= mCount - 1;
         end
         if (wrStb && wr.addr == addrDc)
            mDc <= wr.data[9:0];
         if (wrStb && wr.addr == addrMr)
            mDmd <= wr.data[0];
         if (wrStb && wr.addr == addrCs1)
            mFunc <= wr.data[5:1];
         // Instant seek in diagnostic mode
         if (pendB.seek && mDmd)
         begin
            mCc  <= mDc;
            mAta <= 1'b1;
         end
         if (pendB.seek && !mDmd)
         begin
            mPip     <= 1'b1;
            mSeeking <= 1'b1;
            mCount   <= cylDistance(mDc, mCc) * int'(seekCyclesPerCyl) + int'(seekSettle);
         end
         if (pendB.recal)
         begin
            mPip     <= 1'b1;
            mSeeking <= 1'b0;
            mCount   <= int'(recalCycles);
            mCc      <= '0;
         end
         if (pendB.preset)
         begin
            mCc <= '0;
            mDc <= '0;
         end
      end
   end

   // Expected read data for the address on the bus
   always_comb
   begin
      case (rdAddr)
         addrCs1 : expWord = {10'b0, mFunc, 1'b0};
         addrDs  :
         begin
            expWord        = '0;
            expWord[dsAta] = mAta;
            expWord[dsPip] = mPip;
            expWord[dsDry] = ~mPip;
         end
         addrMr  : expWord = {15'b0, mDmd};
         addrDc  : expWord = {6'b0, mDc};
         addrCc  : expWord = {6'b0, mCc};
         default : expWord = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // Checks, every cycle out of reset
   //////////////////////////////////////////////////

   readCheck : assert property (@(posedge clk) disable iff (rst) rdData == expWord)
      else
      begin
         readErrors = readErrors + 1;
         $display("CHECK FAILED at %0t: rdData at addr %0d expected %h got %h",
                  $time, $sampled(rdAddr), $sampled(expWord), $sampled(rdData));
      end

   ataCheck : assert property (@(posedge clk) disable iff (rst) ata == mAta)
      else
      begin
         ataErrors = ataErrors + 1;
         $display("CHECK FAILED at %0t: ata expected %b got %b",
                  $time, $sampled(mAta), $sampled(ata));
      end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] lfsrNext(logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ lfsrTaps;
      else
         return s >> 1;
   endfunction

   // One LFSR step per bit of the cylinder
   task automatic randomCylinder(output rpCyl_t cyl);
      cyl = '0;
      for (int i = 0; i < 10; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         cyl = {cyl[8:0], lfsrState[0]};
      end
   endtask

   function automatic rpWord_t cs1Word(rpFunc_t func);
      return {10'b0, func, 1'b1};
   endfunction

   // One-cycle write strobe, taken at the next edge
   task automatic busWrite(rpAddr_t addr, rpWord_t data);
      @(posedge clk);
      #1;
      wrStb   = 1'b1;
      wr.addr = addr;
      wr.data = data;
      @(posedge clk);
      #1;
      wrStb = 1'b0;
      wr    = '0;
   endtask

   task automatic idleCycles(int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // Completion of a move or a diagnostic seek
   task automatic waitForAta();
      do
      begin
         @(posedge clk);
         #1;
      end
      while (!ata);
   endtask

   task automatic reportCounts();
      $display("Read check failures: %0d, attention check failures: %0d",
               readErrors, ataErrors);
   endtask

   // DS on both sides of every pip edge
   // Otherwise walk all register addresses, mapped or not
   always @(posedge clk)
   begin
      #1;
      if (pipEdge)
         rdAddr = addrDs;
      else
         rdAddr = rdAddr + 1'b1;
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      rpCyl_t target;
      rst        = 1'b1;
      wrStb      = 1'b0;
      wr         = '0;
      rdAddr     = '0;
      readErrors = 0;
      ataErrors  = 0;
      lfsrState  = 32'd91928;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      idleCycles(8);

      // Timed seeks to random cylinders
      for (int i = 0; i < 4; i++)
      begin
         randomCylinder(target);
         busWrite(addrDc, {6'b0, target});
         busWrite(addrCs1, cs1Word(funcDclr));
         busWrite(addrCs1, cs1Word(funcSeek));
         waitForAta();
         idleCycles(3);
      end

      // Diagnostic mode, instant seek
      busWrite(addrMr, 16'h0001);
      randomCylinder(target);
      busWrite(addrDc, {6'b0, target});
      busWrite(addrCs1, cs1Word(funcDclr));
      busWrite(addrCs1, cs1Word(funcSeek));
      waitForAta();
      busWrite(addrMr, 16'h0000);

      // Preset from a nonzero cylinder
      busWrite(addrCs1, cs1Word(funcDclr));
      busWrite(addrCs1, cs1Word(funcPreset));
      idleCycles(6);

      // Move away, then recalibrate back
      randomCylinder(target);
      busWrite(addrDc, {6'b0, target});
      busWrite(addrCs1, cs1Word(funcSeek));
      waitForAta();
      busWrite(addrCs1, cs1Word(funcDclr));
      busWrite(addrCs1, cs1Word(funcRecal));
      waitForAta();

      // Long seek with commands thrown at it while busy
      busWrite(addrDc, 16'd1000);
      busWrite(addrCs1, cs1Word(funcDclr));
      busWrite(addrCs1, cs1Word(funcSeek));
      idleCycles(20);
      busWrite(addrCs1, cs1Word(funcSeek));
      busWrite(addrCs1, cs1Word(funcRecal));
      busWrite(addrCs1, cs1Word(funcDclr));
      waitForAta();
      busWrite(addrCs1, cs1Word(funcDclr));
      idleCycles(6);

      reportCounts();
      if (readErrors + ataErrors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Run limit
   initial
   begin
      cycleCount = 0;
      while (cycleCount < timeoutCycles)
      begin
         @(posedge clk);
         cycleCount = cycleCount + 1;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      reportCounts();
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: rtl/rpCurrentCylinder.sv
// Current cylinder register, cleared by preset or recalibrate and loaded when a seek completes
module rpCurrentCylinder (
   input  logic             clk,
   input  logic             rst,
   input  rpRegPkg::rpCmd_t cmd,
   input  logic             dmd,
   input  logic             seekDone,
   input  rpRegPkg::rpCyl_t desiredCyl,
   output rpRegPkg::rpCyl_t currentCyl
);

   // Head position, 10-bit cylinder
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         currentCyl <= '0;
      // Preset and recal both return to zero, highest priority
      else if (cmd.preset | cmd.recal)
         currentCyl <= '0;
      // Timed seek finished, or instant seek in diagnostic mode
      else if (seekDone | (cmd.seek & dmd))
         currentCyl <= desiredCyl;
   end

endmodule

// File: rtl/rpDrive.sv
// Drive top level joining function decoder, register file, cylinder register and seek controller
module rpDrive (
   input  logic               clk,
   input  logic               rst,
   input  logic               wrStb,
   input  rpRegPkg::rpBusWr_t wr,
   input  rpRegPkg::rpAddr_t  rdAddr,
   output rpRegPkg::rpWord_t  rdData,
   output logic               ata
);
   import rpRegPkg::*;

   // Function strobes
   rpCmd_t cmd;
   // Cylinders
   rpCyl_t desiredCyl;
   rpCyl_t currentCyl;
   // Drive state
   logic   dmd;
   logic   pip;
   logic   seekDone;

   //////////////////////////////////////////////////
   // Command path
   //////////////////////////////////////////////////

   rpFunctionDecoder decoder (
      .clk   (clk),
      .rst   (rst),
      .wrStb (wrStb),
      .wr    (wr),
      .pip   (pip),
      .cmd   (cmd)
   );

   rpRegisterFile regFile (
      .clk        (clk),
      .rst        (rst),
      .wrStb      (wrStb),
      .wr         (wr),
      .cmd        (cmd),
      .currentCyl (currentCyl),
      .pip        (pip),
      .ata        (ata),
      .rdAddr     (rdAddr),
      .rdData     (rdData),
      .desiredCyl (desiredCyl),
      .dmd        (dmd)
   );

   //////////////////////////////////////////////////
   // Positioning
   //////////////////////////////////////////////////

   rpCurrentCylinder curCyl (
      .clk        (clk),
      .rst        (rst),
      .cmd        (cmd),
      .dmd        (dmd),
      .seekDone   (seekDone),
      .desiredCyl (desiredCyl),
      .currentCyl (currentCyl)
   );

   rpSeekController seekCtl (
      .clk        (clk),
      .rst        (rst),
      .cmd        (cmd),
      .dmd        (dmd),
      .desiredCyl (desiredCyl),
      .currentCyl (currentCyl),
      .pip        (pip),
      .seekDone   (seekDone),
      .ata        (ata)
   );

endmodule

// File: rtl/rpFunctionDecoder.sv
// Turns CS1 writes with GO set into registered one-cycle function strobes, gated by drive busy
module rpFunctionDecoder (
   input  logic              clk,
   input  logic              rst,
   input  logic              wrStb,
   input  rpRegPkg::rpBusWr_t wr,
   input  logic              pip,
   output rpRegPkg::rpCmd_t  cmd
);
   import rpRegPkg::*;

   // GO write captured at the write edge
   logic    goPending;
   // Function field of that write
   rpFunc_t goFunc;
   // Positioning already running or about to start
   logic    busy;
   // Decoded strobes, registered on the next edge
   rpCmd_t  cmdNext;

   //////////////////////////////////////////////////
   // Stage 1, capture the CS1 write
   //////////////////////////////////////////////////

   // Only CS1 writes with GO (bit 0) start a function
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         goPending <= 1'b0;
      else
         goPending <= wrStb & (wr.addr == addrCs1) & wr.data[0];
   end

   // Function code payload
   always_ff @(posedge clk)
   begin
      goFunc <= wr.data[5:1];
   end

   //////////////////////////////////////////////////
   // Stage 2, decode and strobe
   //////////////////////////////////////////////////

   // A seek or recal strobe in flight counts as busy too
   assign busy = pip | cmd.seek | cmd.recal;

   always_comb
   begin
      cmdNext = '0;
      if (goPending)
      begin
         case (goFunc)
            funcNop    : cmdNext = '0;
            // Positioning commands dropped while busy
            funcSeek   : cmdNext.seek   = ~busy;
            funcRecal  : cmdNext.recal  = ~busy;
            funcDclr   : cmdNext.dclr   = 1'b1;
            funcPreset : cmdNext.preset = 1'b1;
            // Unsupported codes do nothing
            default    : cmdNext = '0;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cmd <= '0;
      else
         cmd <= cmdNext;
   end

endmodule

// File: rtl/rpRegPkg.sv
// Register map, bus write format and function strobes shared by the drive RTL and testbench
package rpRegPkg;

   //////////////////////////////////////////////////
   // Widths with a meaning
   //////////////////////////////////////////////////

   // One register word on the bus
   typedef logic [15:0] rpWord_t;
   // Cylinder address, low 10 bits only
   typedef logic [9:0]  rpCyl_t;
   // Register select
   typedef logic [2:0]  rpAddr_t;
   // Function field, CS1 bits 5..1
   typedef logic [4:0]  rpFunc_t;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////

   localparam rpAddr_t addrCs1 = 3'd0;
   localparam rpAddr_t addrDs  = 3'd1;
   localparam rpAddr_t addrMr  = 3'd3;
   localparam rpAddr_t addrDc  = 3'd5;
   localparam rpAddr_t addrCc  = 3'd6;

   // Function codes kept in this model
   localparam rpFunc_t funcNop    = 5'd0;
   localparam rpFunc_t funcSeek   = 5'd2;
   localparam rpFunc_t funcRecal  = 5'd3;
   localparam rpFunc_t funcDclr   = 5'd4;
   localparam rpFunc_t funcPreset = 5'd8;

   // Drive status bit positions
   localparam int dsAta = 15;
   localparam int dsPip = 13;
   localparam int dsDry = 7;

   // Single-cycle bus write, 19 bits
   typedef struct packed {
      rpAddr_t addr;
      rpWord_t data;
   } rpBusWr_t;

   // One-cycle function strobes out of the decoder
   typedef struct packed {
      logic preset;
      logic recal;
      logic seek;
      logic dclr;
   } rpCmd_t;

endpackage

// File: rtl/rpRegisterFile.sv
// Holds the desired cylinder and maintenance registers and multiplexes all drive register reads
module rpRegisterFile (
   input  logic               clk,
   input  logic               rst,
   input  logic               wrStb,
   input  rpRegPkg::rpBusWr_t wr,
   input  rpRegPkg::rpCmd_t   cmd,
   input  rpRegPkg::rpCyl_t   currentCyl,
   input  logic               pip,
   input  logic               ata,
   input  rpRegPkg::rpAddr_t  rdAddr,
   output rpRegPkg::rpWord_t  rdData,
   output rpRegPkg::rpCyl_t   desiredCyl,
   output logic               dmd
);
   import rpRegPkg::*;

   // Stored register contents
   rpCyl_t  dcReg;
   logic    mrDmd;
   rpFunc_t csFunc;

   // Per-register write enables
   logic    wrCs1;
   logic    wrMr;
   logic    wrDc;

   // Assembled drive status word
   rpWord_t dsWord;

   assign wrCs1 = wrStb & (wr.addr == addrCs1);
   assign wrMr  = wrStb & (wr.addr == addrMr);
   assign wrDc  = wrStb & (wr.addr == addrDc);

   //////////////////////////////////////////////////
   // Writable registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dcReg  <= '0;
         mrDmd  <= 1'b0;
         csFunc <= '0;
      end
      else
      begin
         // Preset wins over a DC write in the same cycle
         if (cmd.preset)
            dcReg <= '0;
         else if (wrDc)
            dcReg <= wr.data[9:0];
         // MR bit 0 is diagnostic mode
         if (wrMr)
            mrDmd <= wr.data[0];
         // Function field kept for readback
         if (wrCs1)
            csFunc <= wr.data[5:1];
      end
   end

   assign desiredCyl = dcReg;
   assign dmd        = mrDmd;

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   // DRY is simply not positioning
   always_comb
   begin
      dsWord        = '0;
      dsWord[dsAta] = ata;
      dsWord[dsPip] = pip;
      dsWord[dsDry] = ~pip;
   end

   always_comb
   begin
      case (rdAddr)
         // GO always reads back as zero
         addrCs1 : rdData = {10'b0, csFunc, 1'b0};
         addrDs  : rdData = dsWord;
         addrMr  : rdData = {15'b0, mrDmd};
         addrDc  : rdData = {6'b0, dcReg};
         addrCc  : rdData = {6'b0, currentCyl};
         // Unmapped
         default : rdData = '0;
      endcase
   end

endmodule

// File: rtl/rpSeekController.sv
// Seek and recalibrate timer FSM producing positioning-in-progress, seek done and attention
module rpSeekController (
   input  logic             clk,
   input  logic             rst,
   input  rpRegPkg::rpCmd_t cmd,
   input  logic             dmd,
   input  rpRegPkg::rpCyl_t desiredCyl,
   input  rpRegPkg::rpCyl_t currentCyl,
   output logic             pip,
   output logic             seekDone,
   output logic             ata
);
   import rpRegPkg::*;
   import rpSeekPkg::*;

   rpSeekState_t state;
   rpSeekCount_t count;

   // Head travel and the time it takes
   rpCyl_t       distance;
   rpSeekCount_t seekTime;

   // Decoded events
   logic         startSeek;
   logic         startRecal;
   logic         lastCycle;
   logic         posDone;

   //////////////////////////////////////////////////
   // Seek time
   //////////////////////////////////////////////////

   // Absolute cylinder difference
   always_comb
   begin
      if (desiredCyl >= currentCyl)
         distance = desiredCyl - currentCyl;
      else
         distance = currentCyl - desiredCyl;
   end

   // Travel time plus settle, never zero
   assign seekTime = rpSeekCount_t'(distance) * seekCyclesPerCyl + seekSettle;

   // Diagnostic seeks are instant, no timer
   assign startSeek  = cmd.seek & ~dmd & (state == stIdle);
   assign startRecal = cmd.recal & (state == stIdle);

   assign lastCycle = (count == rpSeekCount_t'(1));

   //////////////////////////////////////////////////
   // Timer FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= stIdle;
         count <= '0;
      end
      else
      begin
         case (state)
            stIdle :
            begin
               if (startRecal)
               begin
                  state <= stRecal;
                  count <= recalCycles;
               end
               else if (startSeek)
               begin
                  state <= stSeek;
                  count <= seekTime;
               end
            end
            // Both moves count down the same way
            stSeek, stRecal :
            begin
               if (lastCycle)
                  state <= stIdle;
               else
                  count <= count - 1'b1;
            end
            default :
               state <= stIdle;
         endcase
      end
   end

   // Busy for the whole move
   assign pip = (state != stIdle);

   // Only a seek loads the cylinder register
   assign seekDone = (state == stSeek) & lastCycle;
   assign posDone  = pip & lastCycle;

   //////////////////////////////////////////////////
   // Attention
   //////////////////////////////////////////////////

   // Set beats DCLR in the same cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (posDone | (cmd.seek & dmd))
         ata <= 1'b1;
      else if (cmd.dclr)
         ata <= 1'b0;
   end

endmodule

// File: rtl/rpSeekPkg.sv
// Seek and recalibrate timing constants, countdown type and seek FSM states for the drive
package rpSeekPkg;

   //////////////////////////////////////////////////
   // Timing
   //////////////////////////////////////////////////

   // Countdown, wide enough for a full-stroke seek
   typedef logic [15:0] rpSeekCount_t;

   // Cycles per cylinder of head travel
   localparam rpSeekCount_t seekCyclesPerCyl = 16'd4;

   // Fixed head settle, added to every timed seek
   localparam rpSeekCount_t seekSettle = 16'd8;

   // Whole recalibrate, independent of position
   localparam rpSeekCount_t recalCycles = 16'd64;

   //////////////////////////////////////////////////
   // Seek controller states
   //////////////////////////////////////////////////

   // stIdle   heads on cylinder, DRY
   // stSeek   timed move to the desired cylinder
   // stRecal  return to cylinder zero
   typedef enum logic [1:0] {
      stIdle,
      stSeek,
      stRecal
   } rpSeekState_t;

endpackage

// File: tb.f
rtl/rpRegPkg.sv
rtl/rpSeekPkg.sv
rtl/rpFunctionDecoder.sv
rtl/rpRegisterFile.sv
rtl/rpCurrentCylinder.sv
rtl/rpSeekController.sv
rtl/rpDrive.sv
dv/rpDriveTb.sv
